// File: fmrt_core.f
+incdir+hdl
hdl/core_pkg.sv
hdl/gpr_file.sv
hdl/insn_fetch.sv
hdl/insn_queue.sv
hdl/exec_unit.sv
hdl/core_top.sv
verification/core_tb.sv

// File: hdl/core_config.svh
//////////////////////////////////////////////////
// Core configuration
// Widths, sizes and opcode encodings shared by
// the fetch, queue and execute blocks
//////////////////////////////////////////////////

`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

//////////////////////////////////////////////////
// Datapath and storage sizes
//////////////////////////////////////////////////
`define WORD_W      32              // Data and instruction width
`define GPR_NUM     32              // Architectural registers, x0 included
`define IMEM_DEPTH  64              // Instruction scratch pad words
`define IMEM_AW     6               // Scratch pad address bits

//////////////////////////////////////////////////
// Instruction queue
//////////////////////////////////////////////////
`define IQ_DEPTH    4               // Queue entries
`define IQ_CW       3               // Occupancy bits, holds 0..IQ_DEPTH

//////////////////////////////////////////////////
// RV32I opcodes of the supported subset
//////////////////////////////////////////////////
`define OPC_OP      7'b0110011      // Register-register ALU
`define OPC_OP_IMM  7'b0010011      // Register-immediate ALU
`define OPC_LUI     7'b0110111      // Load upper immediate

`endif

// File: hdl/core_pkg.sv
//////////////////////////////////////////////////
// Core package
// Common vector types and the enums of the ALU
// and fetch state machine
//////////////////////////////////////////////////

`include "core_config.svh"

package core_pkg;

    // Plain vectors carrying a meaning
    typedef logic [`WORD_W-1:0]  word_t;       // Data or instruction word
    typedef logic [`IMEM_AW-1:0] imem_addr_t;  // Scratch pad word address
    typedef logic [4:0]          reg_addr_t;   // GPR index
    typedef logic [`IQ_CW-1:0]   iq_count_t;   // Queue occupancy

    //////////////////////////////////////////////////
    // ALU operation select
    //////////////////////////////////////////////////
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,                       // a + b
        ALU_SUB  = 4'd1,                       // a - b
        ALU_AND  = 4'd2,                       // Bitwise and
        ALU_OR   = 4'd3,                       // Bitwise or
        ALU_XOR  = 4'd4,                       // Bitwise xor
        ALU_SLL  = 4'd5,                       // Shift left logical
        ALU_SRL  = 4'd6,                       // Shift right logical
        ALU_SLT  = 4'd7,                       // Signed less than
        ALU_PASS = 4'd8                        // Forward operand b, LUI
    } alu_op_e;

    //////////////////////////////////////////////////
    // Fetch sequencing
    //////////////////////////////////////////////////
    typedef enum logic [1:0] {
        FS_IDLE = 2'd0,                        // Waiting for run
        FS_RUN  = 2'd1,                        // Issuing reads
        FS_DONE = 2'd2                         // Last address issued
    } fetch_state_e;

endpackage

// File: hdl/core_top.sv
//////////////////////////////////////////////////
// Core top level
// Fetch, instruction queue and execute chained
// into a single-hart integer core
//////////////////////////////////////////////////

`timescale 1ns/10ps

module core_top import core_pkg::*; (
    input  logic         clk,            // Clock
    input  logic         i_rst_n,        // Sync reset, active low
    input  logic         i_run,          // Start fetching
    input  logic         i_ex_hold,      // Stall execute
    input  logic         i_imem_we,      // Program load strobe
    input  imem_addr_t   i_imem_addr,    // Program load address
    input  word_t        i_imem_wdata,   // Program load data
    output logic         o_wb_valid,     // Write-back valid
    output reg_addr_t    o_wb_rd,        // Write-back register
    output word_t        o_wb_data       // Write-back value
);

    //////////////////////////////////////////////////
    // Internal links
    //////////////////////////////////////////////////
    logic        if_push;                // Fetch to queue strobe
    word_t       if_insn;                // Fetched word
    iq_count_t   iq_count;               // Queue occupancy back to fetch
    word_t       iq_head;                // Head word to execute
    logic        iq_empty;               // Queue empty
    logic        ex_pop;                 // Execute consumes head

    // Fetch stage
    insn_fetch insn_fetch (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_run         (i_run),
        .i_imem_we     (i_imem_we),      // Load port passes through
        .i_imem_addr   (i_imem_addr),
        .i_imem_wdata  (i_imem_wdata),
        .i_iq_count    (iq_count),       // Issue throttle
        .o_push        (if_push),
        .o_insn        (if_insn)
    );

    // Decoupling buffer
    insn_queue insn_queue (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_push        (if_push),
        .i_insn        (if_insn),
        .i_pop         (ex_pop),
        .o_head        (iq_head),
        .o_empty       (iq_empty),
        .o_count       (iq_count)
    );

    // Decode, ALU and write-back
    exec_unit exec_unit (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_head        (iq_head),
        .i_empty       (iq_empty),
        .i_ex_hold     (i_ex_hold),      // Only back-pressure source
        .o_pop         (ex_pop),
        .o_wb_valid    (o_wb_valid),
        .o_wb_rd       (o_wb_rd),
        .o_wb_data     (o_wb_data)
    );

endmodule

// File: hdl/exec_unit.sv
//////////////////////////////////////////////////
// Execute unit
// Pops the queue head, decodes it, reads the GPRs,
// runs the ALU and registers the write-back
//////////////////////////////////////////////////

`timescale 1ns/10ps

`include "core_config.svh"

module exec_unit import core_pkg::*; (
    input  logic         clk,            // Clock
    input  logic         i_rst_n,        // Sync reset, active low
    input  word_t        i_head,         // Queue head word
    input  logic         i_empty,        // Queue empty
    input  logic         i_ex_hold,      // External hold level
    output logic         o_pop,          // Consume head
    output logic         o_wb_valid,     // Write-back valid
    output reg_addr_t    o_wb_rd,        // Write-back register
    output word_t        o_wb_data       // Write-back value
);

    logic [6:0]  opcode;                 // Instruction fields
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    word_t       rs1_data;               // GPR read data
    word_t       rs2_data;
    word_t       imm;                    // Selected immediate
    word_t       op_b;                   // ALU operand b
    word_t       alu_res;                // ALU result
    alu_op_e     alu_op;
    logic        use_imm;
    logic        legal;                  // Supported encoding
    logic        wb_we;                  // GPR write this cycle

    assign opcode = i_head[6:0];
    assign rd     = i_head[11:7];
    assign funct3 = i_head[14:12];
    assign rs1    = i_head[19:15];
    assign rs2    = i_head[24:20];
    assign funct7 = i_head[31:25];

    assign o_pop  = !i_empty && !i_ex_hold;

    //////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////
    always_comb begin
        alu_op  = ALU_ADD;
        use_imm = 1'b0;
        legal   = 1'b0;
        imm     = {{(`WORD_W-12){i_head[31]}}, i_head[31:20]};  // I-type, sign extended
        case (opcode)
            `OPC_OP: begin
                // Only SUB may set funct7[5]
                legal = (funct7 == 7'h00) || (funct7 == 7'h20 && funct3 == 3'b000);
                case (funct3)
                    3'b000:  alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b111:  alu_op = ALU_AND;
                    3'b110:  alu_op = ALU_OR;
                    3'b100:  alu_op = ALU_XOR;
                    3'b001:  alu_op = ALU_SLL;
                    3'b101:  alu_op = ALU_SRL;
                    3'b010:  alu_op = ALU_SLT;
                    default: legal  = 1'b0;       // SLTU not supported
                endcase
            end
            `OPC_OP_IMM: begin
                use_imm = 1'b1;
                legal   = 1'b1;
                case (funct3)
                    3'b000:  alu_op = ALU_ADD;    // ADDI
                    3'b111:  alu_op = ALU_AND;    // ANDI
                    3'b110:  alu_op = ALU_OR;     // ORI
                    3'b100:  alu_op = ALU_XOR;    // XORI
                    default: legal  = 1'b0;       // Shifts and compares left out
                endcase
            end
            `OPC_LUI: begin
                use_imm = 1'b1;
                legal   = 1'b1;
                alu_op  = ALU_PASS;
                imm     = {i_head[31:12], 12'b0}; // U-type
            end
            default: legal = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////
    assign op_b = use_imm ? imm : rs2_data;

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_res = rs1_data + op_b;
            ALU_SUB:  alu_res = rs1_data - op_b;
            ALU_AND:  alu_res = rs1_data & op_b;
            ALU_OR:   alu_res = rs1_data | op_b;
            ALU_XOR:  alu_res = rs1_data ^ op_b;
            ALU_SLL:  alu_res = rs1_data << op_b[4:0];
            ALU_SRL:  alu_res = rs1_data >> op_b[4:0];
            ALU_SLT:  alu_res = {{(`WORD_W-1){1'b0}}, $signed(rs1_data) < $signed(op_b)};
            ALU_PASS: alu_res = op_b;
            default:  alu_res = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Write-back, GPR updated on the same edge
    //////////////////////////////////////////////////
    assign wb_we = o_pop && legal && (rd != '0);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_wb_valid <= 1'b0;
        end else begin
            o_wb_valid <= wb_we;
        end
    end

    always_ff @(posedge clk) begin
        if (o_pop) begin
            o_wb_rd   <= rd;
            o_wb_data <= alu_res;
        end
    end

    gpr_file gpr_file (
        .clk         (clk),              // Clock
        .i_rst_n     (i_rst_n),          // Reset
        .i_rs1_addr  (rs1),              // Read port 0
        .i_rs2_addr  (rs2),              // Read port 1
        .i_we        (wb_we),            // Write enable
        .i_wr_addr   (rd),               // Write address
        .i_wr_data   (alu_res),          // Write data
        .o_rs1_data  (rs1_data),
        .o_rs2_data  (rs2_data)
    );

endmodule

// File: hdl/gpr_file.sv
//////////////////////////////////////////////////
// General purpose registers
// Two combinational read ports, one write port,
// x0 hardwired to zero
//////////////////////////////////////////////////

`timescale 1ns/10ps

`include "core_config.svh"

module gpr_file import core_pkg::*; (
    input  logic         clk,            // Clock
    input  logic         i_rst_n,        // Sync reset, active low
    input  reg_addr_t    i_rs1_addr,     // Read address 0
    input  reg_addr_t    i_rs2_addr,     // Read address 1
    input  logic         i_we,           // Write enable
    input  reg_addr_t    i_wr_addr,      // Write address
    input  word_t        i_wr_data,      // Write data
    output word_t        o_rs1_data,     // Read data 0
    output word_t        o_rs2_data      // Read data 1
);

    word_t regs [1:`GPR_NUM-1];          // x1..x31, no storage for x0

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int i = 1; i < `GPR_NUM; i++) begin
                regs[i] <= '0;           // Architectural reset to zero
            end
        end else if (i_we && (i_wr_addr != '0)) begin
            regs[i_wr_addr] <= i_wr_data;  // Writes to x0 dropped
        end
    end

    // x0 decoded here, never looked up
    assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

// File: hdl/insn_fetch.sv
//////////////////////////////////////////////////
// Instruction fetch
// Owns the instruction scratch pad and the PC,
// reads one word per cycle and pushes it into the
// instruction queue while the queue has room
//////////////////////////////////////////////////

`timescale 1ns/10ps

`include "core_config.svh"

module insn_fetch import core_pkg::*; (
    input  logic         clk,            // Clock
    input  logic         i_rst_n,        // Sync reset, active low
    input  logic         i_run,          // Run level
    input  logic         i_imem_we,      // Load write strobe
    input  imem_addr_t   i_imem_addr,    // Load address
    input  word_t        i_imem_wdata,   // Load data
    input  iq_count_t    i_iq_count,     // Queue occupancy
    output logic         o_push,         // Push strobe to queue
    output word_t        o_insn          // Pushed word
);

    localparam imem_addr_t LAST_ADDR = imem_addr_t'(`IMEM_DEPTH - 1);

    word_t           imem [0:`IMEM_DEPTH-1];  // Scratch pad array
    fetch_state_e    state;                   // Fetch FSM
    imem_addr_t      pc;                      // Next address to read
    logic [`IQ_CW:0] fill_level;              // Queue count plus read in flight
    logic            issue;                   // Read issued this cycle

    // A read issued last cycle shows up as o_push now and is not yet counted
    assign fill_level = {1'b0, i_iq_count} + {{`IQ_CW{1'b0}}, o_push};
    assign issue      = (state == FS_RUN) && i_run && (fill_level < `IQ_DEPTH);

    //////////////////////////////////////////////////
    // Scratch pad, external write and sync read
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (i_imem_we) begin
            imem[i_imem_addr] <= i_imem_wdata;  // Program load
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            o_insn <= imem[pc];                 // Word valid with o_push
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_push <= 1'b0;
        end else begin
            o_push <= issue;                    // One cycle read latency
        end
    end

    //////////////////////////////////////////////////
    // PC and state machine
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state <= FS_IDLE;
            pc    <= '0;
        end else begin
            case (state)
                FS_IDLE: begin
                    if (i_run) begin
                        state <= FS_RUN;        // Start from address 0
                        pc    <= '0;
                    end
                end
                FS_RUN: begin
                    if (issue) begin
                        if (pc == LAST_ADDR) begin
                            state <= FS_DONE;   // Program exhausted
                        end else begin
                            pc <= pc + 1'b1;
                        end
                    end
                end
                FS_DONE: state <= FS_DONE;      // Park until reset
                default: state <= FS_IDLE;
            endcase
        end
    end

endmodule

// File: hdl/insn_queue.sv
//////////////////////////////////////////////////
// Instruction queue
// Circular FIFO of instruction words between
// fetch and execute, with occupancy count
//////////////////////////////////////////////////

`timescale 1ns/10ps

`include "core_config.svh"

module insn_queue import core_pkg::*; (
    input  logic         clk,            // Clock
    input  logic         i_rst_n,        // Sync reset, active low
    input  logic         i_push,         // Write strobe from fetch
    input  word_t        i_insn,         // Word to write
    input  logic         i_pop,          // Read strobe from execute
    output word_t        o_head,         // Oldest word
    output logic         o_empty,        // No words held
    output iq_count_t    o_count         // Words held
);

    localparam int PTR_W = $clog2(`IQ_DEPTH);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(`IQ_DEPTH - 1);

    word_t            q_mem [0:`IQ_DEPTH-1];  // Entry storage
    logic [PTR_W-1:0] wr_ptr;                 // Next slot to fill
    logic [PTR_W-1:0] rd_ptr;                 // Head slot
    iq_count_t        count;                  // Occupancy

    // Wrap explicitly so a depth that is not a power of two still works
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        ptr_inc = (ptr == PTR_LAST) ? '0 : ptr + 1'b1;
    endfunction

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (i_push) begin
            q_mem[wr_ptr] <= i_insn;
        end
    end

    //////////////////////////////////////////////////
    // Pointers and count
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (i_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({i_push, i_pop})
                2'b10:   count <= count + 1'b1;   // Push only
                2'b01:   count <= count - 1'b1;   // Pop only
                default: count <= count;          // Both or neither
            endcase
        end
    end

    assign o_head  = q_mem[rd_ptr];   // Shown straight from storage
    assign o_empty = (count == '0);
    assign o_count = count;

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the core testbench with Verilator, run it and scan the log.
# The exit status is 0 only when the testbench reports a pass.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f fmrt_core.f \
    --top-module core_tb \
    -o Vcore_tb \
    && ./obj_dir/Vcore_tb > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null \
    ; grep -q "^TEST PASS$" sim.log \
    && echo "Simulation finished: pass" \
    || { echo "Simulation finished: fail"; exit 1; }

// File: verification/core_tb.sv
//////////////////////////////////////////////////
// Core testbench
// Loads a random program, runs the core against a
// reference model and checks every write-back
//////////////////////////////////////////////////

`timescale 1ns/10ps

`include "core_config.svh"

module core_tb import core_pkg::*; ();

    localparam int NUM_INSN    = `IMEM_DEPTH;
    localparam int TIMEOUT_CYC = NUM_INSN * 8 + 200;   // Worst case under hold plus margin
    localparam int QUIET_CYC   = 20;                   // Watch for stray write-backs
    localparam int NUM_TESTS   = 6;

    logic        clk;
    logic        i_rst_n;
    logic        i_run;
    logic        i_ex_hold;
    logic        i_imem_we;
    imem_addr_t  i_imem_addr;
    word_t       i_imem_wdata;
    logic        o_wb_valid;
    reg_addr_t   o_wb_rd;
    word_t       o_wb_data;

    word_t       prog [0:NUM_INSN-1];      // Program image
    word_t       ref_regs [0:31];          // Model register file
    reg_addr_t   exp_rd [0:NUM_INSN-1];    // Expected write-back list
    word_t       exp_data [0:NUM_INSN-1];
    int          exp_cls [0:NUM_INSN-1];   // Test each entry belongs to
    int          exp_count   = 0;
    int          skipped     = 0;          // rd x0 or illegal
    int          dep_count   = 0;
    int          wb_idx      = 0;          // Write-backs seen
    int          run_cycles  = 0;
    int          seed        = 88028;
    int          errs [0:NUM_TESTS-1];
    int          chks [0:NUM_TESTS-1];
    int          cur_idx;
    int          cur_cls;
    reg_addr_t   cur_rd;
    word_t       cur_data;
    logic        hold_phase;
    logic [31:0] hold_rnd;

    core_top uut (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_run        (i_run),
        .i_ex_hold    (i_ex_hold),
        .i_imem_we    (i_imem_we),
        .i_imem_addr  (i_imem_addr),
        .i_imem_wdata (i_imem_wdata),
        .o_wb_valid   (o_wb_valid),
        .o_wb_rd      (o_wb_rd),
        .o_wb_data    (o_wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;            // 20 ns period
    end

    // Head of the expected list
    assign cur_idx  = (wb_idx < NUM_INSN) ? wb_idx : 0;
    assign cur_rd   = exp_rd[cur_idx];
    assign cur_data = exp_data[cur_idx];
    assign cur_cls  = exp_cls[cur_idx];

    function automatic string test_name(input int t);
        case (t)
            0:       test_name = "reset_idle";
            1:       test_name = "reg_reg";
            2:       test_name = "imm_lui";
            3:       test_name = "dependent";
            4:       test_name = "x0_illegal";
            default: test_name = "hold_random";
        endcase
    endfunction

    task automatic note_mismatch(input int t, input string what, input word_t exp,
                                 input word_t act);
        errs[t]++;
        $display("Mismatch in %s: %s expected 0x%08h, actual 0x%08h",
                 test_name(t), what, exp, act);
    endtask

    task automatic report_failure(input int t, input string msg);
        errs[t]++;
        $display("Error in %s: %s", test_name(t), msg);
    endtask

    //////////////////////////////////////////////////
    // Program generation and reference model
    //////////////////////////////////////////////////
    task automatic build_program();
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        int          kind;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        reg_addr_t   prev_rd;
        word_t       a;
        word_t       b;
        word_t       res;
        logic [6:0]  bad_opc;
        logic        wr;
        logic        dep;
        prev_rd = 5'd0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        for (int i = 0; i < NUM_INSN; i++) begin
            r0   = $random(seed);
            r1   = $random(seed);
            r2   = $random(seed);
            kind = int'(r0[7:0]) % 15;                          // 0-7 RR, 8-11 imm, 12-13 LUI
            rd   = (r1[3:0] < 4'd2) ? 5'd0 : r1[8:4];           // x0 about one in eight
            rs1  = r1[13:9];
            rs2  = r1[18:14];
            if (r1[23:21] == 3'd0) begin
                rs1 = 5'd0;                                     // Force an x0 source
            end else if (r0[8] && prev_rd != 5'd0) begin
                rs1 = prev_rd;                                  // Chain on last result
            end
            if (r0[9] && prev_rd != 5'd0) begin
                rs2 = prev_rd;
            end
            a   = ref_regs[rs1];
            b   = (kind < 8) ? ref_regs[rs2] : {{20{r2[11]}}, r2[11:0]};
            wr  = 1'b1;
            dep = (kind < 12) && (prev_rd != 5'd0) &&
                  ((rs1 == prev_rd) || (kind < 8 && rs2 == prev_rd));
            case (kind)
                0: begin
                    res     = a + b;
                    prog[i] = {7'h00, rs2, rs1, 3'b000, rd, `OPC_OP};
                end
                1: begin
                    res     = a - b;
                    prog[i] = {7'h20, rs2, rs1, 3'b000, rd, `OPC_OP};
                end
                2: begin
                    res     = a & b;
                    prog[i] = {7'h00, rs2, rs1, 3'b111, rd, `OPC_OP};
                end
                3: begin
                    res     = a | b;
                    prog[i] = {7'h00, rs2, rs1, 3'b110, rd, `OPC_OP};
                end
                4: begin
                    res     = a ^ b;
                    prog[i] = {7'h00, rs2, rs1, 3'b100, rd, `OPC_OP};
                end
                5: begin
                    res     = a << b[4:0];
                    prog[i] = {7'h00, rs2, rs1, 3'b001, rd, `OPC_OP};
                end
                6: begin
                    res     = a >> b[4:0];
                    prog[i] = {7'h00, rs2, rs1, 3'b101, rd, `OPC_OP};
                end
                7: begin
                    res     = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    prog[i] = {7'h00, rs2, rs1, 3'b010, rd, `OPC_OP};
                end
                8: begin
                    res     = a + b;                            // ADDI
                    prog[i] = {r2[11:0], rs1, 3'b000, rd, `OPC_OP_IMM};
                end
                9: begin
                    res     = a & b;                            // ANDI
                    prog[i] = {r2[11:0], rs1, 3'b111, rd, `OPC_OP_IMM};
                end
                10: begin
                    res     = a | b;                            // ORI
                    prog[i] = {r2[11:0], rs1, 3'b110, rd, `OPC_OP_IMM};
                end
                11: begin
                    res     = a ^ b;                            // XORI
                    prog[i] = {r2[11:0], rs1, 3'b100, rd, `OPC_OP_IMM};
                end
                12, 13: begin
                    res     = {r2[31:12], 12'h000};
                    prog[i] = {r2[31:12], rd, `OPC_LUI};
                end
                default: begin
                    // Load, store, branch and JAL opcodes are outside the subset
                    case (r0[11:10])
                        2'd0:    bad_opc = 7'b0000011;
                        2'd1:    bad_opc = 7'b0100011;
                        2'd2:    bad_opc = 7'b1100011;
                        default: bad_opc = 7'b1101111;
                    endcase
                    res     = '0;
                    wr      = 1'b0;
                    prog[i] = {r2[24:0], bad_opc};
                end
            endcase
            if (wr && rd != 5'd0) begin
                ref_regs[rd]        = res;
                exp_rd[exp_count]   = rd;
                exp_data[exp_count] = res;
                exp_cls[exp_count]  = dep ? 3 : ((kind < 8) ? 1 : 2);
                dep_count           = dep_count + (dep ? 1 : 0);
                exp_count++;
                prev_rd = rd;
            end else begin
                skipped++;
                prev_rd = 5'd0;                                 // No result to chain on
            end
        end
        for (int i = exp_count / 2; i < exp_count; i++) begin
            exp_cls[i] = 5;                                     // Second half runs under hold
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < NUM_INSN; i++) begin
            @(negedge clk);
            i_imem_we    = 1'b1;
            i_imem_addr  = imem_addr_t'(i);
            i_imem_wdata = prog[i];
        end
        @(negedge clk);
        i_imem_we = 1'b0;
    endtask

    task automatic print_test(input int t);
        if (errs[t] == 0) begin
            $display("%s: passed, %0d checks", test_name(t), chks[t]);
        end else begin
            $display("%s: failed, %0d errors in %0d checks", test_name(t), errs[t], chks[t]);
        end
    endtask

    //////////////////////////////////////////////////
    // Monitors, random hold and timeout
    //////////////////////////////////////////////////
    always @(posedge clk) begin
        if (i_rst_n && !i_run) begin
            chks[0]++;                                          // Idle cycle watched
        end
        if (i_rst_n && o_wb_valid) begin
            if (wb_idx < exp_count) begin
                chks[cur_cls]++;
            end
            wb_idx <= wb_idx + 1;
        end
    end

    always @(negedge clk) begin
        if (hold_phase) begin
            hold_rnd  = $random(seed);
            i_ex_hold = (hold_rnd[1:0] != 2'b00);               // Held three cycles in four
        end
    end

    always @(posedge clk) begin
        if (i_run) begin
            run_cycles <= run_cycles + 1;
            if (run_cycles >= TIMEOUT_CYC) begin
                $display("Timeout: write-backs did not complete, %0d of %0d seen in %0d cycles",
                         wb_idx, exp_count, run_cycles);
                $display("TEST FAIL");
                $finish;
            end
        end
    end

    //////////////////////////////////////////////////
    // Write-back checks
    //////////////////////////////////////////////////
    assert property (@(posedge clk) disable iff (!i_rst_n) !i_run |-> !o_wb_valid)
        else report_failure(0, "o_wb_valid went high before i_run");

    assert property (@(posedge clk) disable iff (!i_rst_n)
                     (o_wb_valid && wb_idx < exp_count) |-> (o_wb_rd == cur_rd))
        else note_mismatch($sampled(cur_cls), "rd", 32'($sampled(cur_rd)),
                           32'($sampled(o_wb_rd)));

    assert property (@(posedge clk) disable iff (!i_rst_n)
                     (o_wb_valid && wb_idx < exp_count) |-> (o_wb_data == cur_data))
        else note_mismatch($sampled(cur_cls), "data", $sampled(cur_data),
                           $sampled(o_wb_data));

    assert property (@(posedge clk) disable iff (!i_rst_n) o_wb_valid |-> (wb_idx < exp_count))
        else report_failure(4, "write-back seen after the expected sequence ended");

    assert property (@(posedge clk) disable iff (!i_rst_n) o_wb_valid |-> (o_wb_rd != 5'd0))
        else report_failure(4, "write-back reported for x0");

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        int    total_err;
        int    failed;
        string summary;
        i_rst_n      = 1'b0;
        i_run        = 1'b0;
        i_ex_hold    = 1'b0;
        i_imem_we    = 1'b0;
        i_imem_addr  = '0;
        i_imem_wdata = '0;
        hold_phase   = 1'b0;
        total_err    = 0;
        failed       = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            errs[t] = 0;
            chks[t] = 0;
        end
        build_program();
        repeat (16) @(posedge clk);                             // Reset over 16 edges
        @(negedge clk);
        i_rst_n = 1'b1;
        load_program();                                         // Run still low
        @(negedge clk);
        print_test(0);
        i_run = 1'b1;
        while (wb_idx < exp_count / 2) @(posedge clk);
        hold_phase = 1'b1;                                      // Random hold from here
        while (wb_idx < exp_count) @(posedge clk);
        hold_phase = 1'b0;
        @(negedge clk);
        i_ex_hold = 1'b0;
        repeat (QUIET_CYC) @(negedge clk);
        chks[4] = skipped + 1;
        assert (wb_idx == exp_count)
            else report_failure(4, $sformatf("%0d write-backs seen, model expects %0d",
                                             wb_idx, exp_count));
        for (int t = 1; t < NUM_TESTS; t++) begin
            print_test(t);
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            total_err += errs[t];
            failed    += (errs[t] != 0) ? 1 : 0;
        end
        summary = $sformatf("Summary: %0d tests, %0d passed, %0d failed,",
                            NUM_TESTS, NUM_TESTS - failed, failed);
        summary = {summary, $sformatf(" %0d of %0d write-backs, %0d dependent, %0d errors",
                                      wb_idx, exp_count, dep_count, total_err)};
        $display("%s", summary);
        if (total_err == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
